//--- ibtb_wrapper.f
+incdir+src
src/ibtb_pkg.sv
src/ibtb_hash.sv
src/ibtb_array.sv
src/ibtb.sv
src/ibtb_wrapper.sv
sim/tb_ibtb_wrapper.sv

//--- sim/ibtb_tests.txt
// asid rd_pc38 rd_gh upd_valid upd_pc38 upd_gh upd_tgt38 exp_tgt38, all hex
// exp is the output seen in that row, so it answers the read two rows earlier
// cold table, every read misses
001 0000001234 00 0 0000000000 00 0000000000 0000000000
001 0000001234 01 0 0000000000 00 0000000000 0000000000
001 0000001274 00 0 0000000000 00 0000000000 0000000000
001 0000000000 00 0 0000000000 00 0000000000 0000000000
// train key a (idx 34 tag 49), same row read sees old entry
001 0000001234 00 1 0000001234 00 000000abcd 0000000000
001 0000001234 00 0 0000000000 00 0000000000 0000000000
001 0000000000 00 0 0000000000 00 0000000000 0000000000
001 0000000000 00 0 0000000000 00 0000000000 000000abcd
// other asid misses, back to asid 1 hits, gh bit 6 only moves the tag
002 0000001234 00 0 0000000000 00 0000000000 0000000000
001 0000001234 00 0 0000000000 00 0000000000 0000000000
001 0000001234 40 0 0000000000 00 0000000000 0000000000
001 0000000000 00 0 0000000000 00 0000000000 000000abcd
001 0000000000 00 0 0000000000 00 0000000000 0000000000
// key c shares idx 34 with tag 48 and evicts key a
001 0000000000 00 1 0000001274 00 2468ace024 0000000000
001 0000001234 00 0 0000000000 00 0000000000 0000000000
001 0000001274 00 0 0000000000 00 0000000000 0000000000
001 0000000000 00 0 0000000000 00 0000000000 0000000000
001 0000000000 00 0 0000000000 00 0000000000 2468ace024
// history only keys land at idx 35 and idx 36
001 0000000000 00 1 0000001234 01 0000001111 0000000000
001 0000000000 00 1 0000001234 02 3000000002 0000000000
001 0000001234 01 0 0000000000 00 0000000000 0000000000
001 0000001234 02 0 0000000000 00 0000000000 0000000000
001 0000001274 00 0 0000000000 00 0000000000 0000001111
001 0000001234 00 0 0000000000 00 0000000000 3000000002
001 0000000000 00 0 0000000000 00 0000000000 2468ace024
001 0000000000 00 0 0000000000 00 0000000000 0000000000
001 0000000000 00 0 0000000000 00 0000000000 0000000000
001 0000000000 00 0 0000000000 00 0000000000 0000000000

//--- sim/tb_ibtb_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "ibtb_defs.svh"

module tb_ibtb_wrapper;

    // ------------------------------
    // test vector layout
    // ------------------------------

    // eight hex fields per row
    // one row per cycle
    localparam int FIELDS   = 8;
    localparam int MAX_ROWS = 64;

    // field positions inside a row
    localparam int F_ASID  = 0;
    localparam int F_RPC   = 1;
    localparam int F_RGH   = 2;
    localparam int F_UV    = 3;
    localparam int F_UPC   = 4;
    localparam int F_UGH   = 5;
    localparam int F_UTGT  = 6;
    localparam int F_EXP   = 7;

    // wide enough for any field
    // unfilled words stay x
    logic [39:0] vec_mem [FIELDS*MAX_ROWS];

    int n_rows;
    int cycle_cnt;
    int timeout_limit;

    // ------------------------------
    // dut signals
    // ------------------------------

    logic               CLK;
    logic               nRST;
    ibtb_pkg::ASID_t    next_arch_asid;
    ibtb_pkg::PC38_t    next_read_src_pc38;
    ibtb_pkg::IBTB_GH_t next_read_ibtb_gh;
    ibtb_pkg::PC38_t    last_read_tgt_pc38;
    logic               next_update_valid;
    ibtb_pkg::PC38_t    next_update_src_pc38;
    ibtb_pkg::IBTB_GH_t next_update_ibtb_gh;
    ibtb_pkg::PC38_t    next_update_tgt_pc38;

    ibtb_wrapper u_dut (
        .CLK                  (CLK),
        .nRST                 (nRST),
        .next_arch_asid       (next_arch_asid),
        .next_read_src_pc38   (next_read_src_pc38),
        .next_read_ibtb_gh    (next_read_ibtb_gh),
        .last_read_tgt_pc38   (last_read_tgt_pc38),
        .next_update_valid    (next_update_valid),
        .next_update_src_pc38 (next_update_src_pc38),
        .next_update_ibtb_gh  (next_update_ibtb_gh),
        .next_update_tgt_pc38 (next_update_tgt_pc38)
    );

    // 40 ns period
    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // ------------------------------
    // helpers
    // ------------------------------

    // present one row of stimulus right after the rising edge
    task automatic drive_row(input int row);
        int base;
        base = row * FIELDS;
        next_arch_asid       <= vec_mem[base + F_ASID][`ASID_BITS-1:0];
        next_read_src_pc38   <= vec_mem[base + F_RPC][`PC38_BITS-1:0];
        next_read_ibtb_gh    <= vec_mem[base + F_RGH][`IBTB_GH_BITS-1:0];
        next_update_valid    <= vec_mem[base + F_UV][0];
        next_update_src_pc38 <= vec_mem[base + F_UPC][`PC38_BITS-1:0];
        next_update_ibtb_gh  <= vec_mem[base + F_UGH][`IBTB_GH_BITS-1:0];
        next_update_tgt_pc38 <= vec_mem[base + F_UTGT][`PC38_BITS-1:0];
    endtask

    // predicted target against the file value
    task automatic check_pc(input ibtb_pkg::PC38_t got, input ibtb_pkg::PC38_t exp,
                            input int row);
        if (got !== exp) begin
            $display("ERR last_read_tgt_pc38 row %0d got %h expected %h", row, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // ------------------------------
    // timeout
    // ------------------------------

    // counts cycles once reset is released
    always @(posedge CLK) begin
        if (nRST) begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > timeout_limit) begin
                $display("timeout after %0d cycles without finishing the test rows",
                         cycle_cnt);
                $display(">>> FAIL");
                $fatal(1);
            end
        end
    end

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        nRST                 = 1'b0;
        next_arch_asid       = '0;
        next_read_src_pc38   = '0;
        next_read_ibtb_gh    = '0;
        next_update_valid    = 1'b0;
        next_update_src_pc38 = '0;
        next_update_ibtb_gh  = '0;
        next_update_tgt_pc38 = '0;
        cycle_cnt            = 0;

        $readmemh("sim/ibtb_tests.txt", vec_mem);

        // rows end at the first unfilled asid word
        n_rows = 0;
        while (n_rows < MAX_ROWS && !$isunknown(vec_mem[n_rows * FIELDS + F_ASID])) begin
            n_rows = n_rows + 1;
        end
        timeout_limit = n_rows + 20;

        // hold reset for 5 cycles
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        // drive on the rising edge
        // sample at the falling edge
        // the expected column already holds the read from two rows back
        for (int row = 0; row < n_rows; row++) begin
            @(posedge CLK);
            drive_row(row);
            @(negedge CLK);
            check_pc(last_read_tgt_pc38, vec_mem[row * FIELDS + F_EXP][`PC38_BITS-1:0], row);
        end

        if (n_rows == 0) begin
            $display("no test rows were read from sim/ibtb_tests.txt");
            $display(">>> FAIL");
            $fatal(1);
        end
        else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- src/ibtb.sv
`timescale 1ns/1ps
`default_nettype none

module ibtb (
    // seq
    input  logic CLK,
    input  logic nRST,

    // arch state
    input  ibtb_pkg::ASID_t    arch_asid,

    // read
    input  ibtb_pkg::PC38_t    read_src_pc38,
    input  ibtb_pkg::IBTB_GH_t read_ibtb_gh,
    output ibtb_pkg::PC38_t    read_tgt_pc38,

    // update
    input  logic               update_valid,
    input  ibtb_pkg::PC38_t    update_src_pc38,
    input  ibtb_pkg::IBTB_GH_t update_ibtb_gh,
    input  ibtb_pkg::PC38_t    update_tgt_pc38
);

    // ------------------------------
    // read side hash
    // ------------------------------

    ibtb_pkg::IBTB_index_t read_index;
    ibtb_pkg::IBTB_tag_t   read_tag;

    ibtb_hash u_read_hash (
        .src_pc38 (read_src_pc38),
        .ibtb_gh  (read_ibtb_gh),
        .asid     (arch_asid),
        .index    (read_index),
        .tag      (read_tag)
    );

    // ------------------------------
    // update side hash
    // ------------------------------

    // same fold as the read so a trained key finds its own slot
    ibtb_pkg::IBTB_index_t update_index;
    ibtb_pkg::IBTB_tag_t   update_tag;

    ibtb_hash u_update_hash (
        .src_pc38 (update_src_pc38),
        .ibtb_gh  (update_ibtb_gh),
        .asid     (arch_asid),
        .index    (update_index),
        .tag      (update_tag)
    );

    // ------------------------------
    // table
    // ------------------------------

    // indexed entry as seen by the read
    logic                entry_valid;
    ibtb_pkg::IBTB_tag_t entry_tag;
    ibtb_pkg::PC38_t     entry_tgt_pc38;

    ibtb_array u_array (
        .CLK            (CLK),
        .nRST           (nRST),
        .read_index     (read_index),
        .read_valid     (entry_valid),
        .read_tag       (entry_tag),
        .read_tgt_pc38  (entry_tgt_pc38),
        .write_en       (update_valid),
        .write_index    (update_index),
        .write_tag      (update_tag),
        .write_tgt_pc38 (update_tgt_pc38)
    );

    // ------------------------------
    // tag compare
    // ------------------------------

    logic read_hit;

    // valid entry with a matching tag
    assign read_hit = entry_valid && (entry_tag == read_tag);

    // miss gives all zeros
    // fetch reads zero as no prediction
    assign read_tgt_pc38 = read_hit ? entry_tgt_pc38 : '0;

    // ------------------------------
    // checks
    // ------------------------------

    // an x target would be trained in and later predicted as a jump
    a_update_tgt_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        update_valid |-> !$isunknown(update_tgt_pc38)
    ) else $error("ibtb: unknown update_tgt_pc38 on update");

endmodule

`default_nettype wire

//--- src/ibtb_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "ibtb_defs.svh"

module ibtb_array (
    // seq
    input  logic CLK,
    input  logic nRST,

    // read port
    // comb lookup straight off the flops
    input  ibtb_pkg::IBTB_index_t read_index,
    output logic                  read_valid,
    output ibtb_pkg::IBTB_tag_t   read_tag,
    output ibtb_pkg::PC38_t       read_tgt_pc38,

    // write port
    input  logic                  write_en,
    input  ibtb_pkg::IBTB_index_t write_index,
    input  ibtb_pkg::IBTB_tag_t   write_tag,
    input  ibtb_pkg::PC38_t       write_tgt_pc38
);

    // ------------------------------
    // storage
    // ------------------------------

    // one valid bit per entry
    logic [`IBTB_ENTRIES-1:0] valid_q;

    // tag per entry
    ibtb_pkg::IBTB_tag_t tag_q [`IBTB_ENTRIES];

    // predicted target per entry
    ibtb_pkg::PC38_t tgt_q [`IBTB_ENTRIES];

    // ------------------------------
    // valid bits
    // ------------------------------

    // cleared on reset so nothing stale can hit
    // set on any write and never cleared otherwise
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end
        else if (write_en) begin
            valid_q[write_index] <= 1'b1;
        end
    end

    // ------------------------------
    // tag and target
    // ------------------------------

    // only meaningful once valid is set
    always_ff @(posedge CLK) begin
        if (write_en) begin
            // overwrite whatever held the slot
            tag_q[write_index] <= write_tag;
            tgt_q[write_index] <= write_tgt_pc38;
        end
    end

    // ------------------------------
    // read
    // ------------------------------

    // async read
    // a write in the same cycle shows up only after the edge
    assign read_valid    = valid_q[read_index];
    assign read_tag      = tag_q[read_index];
    assign read_tgt_pc38 = tgt_q[read_index];

    // ------------------------------
    // checks
    // ------------------------------

    // an x index would smear the write over unknown entries
    // and corrupt valid bits for every later read
    a_write_index_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        write_en |-> !$isunknown(write_index)
    ) else $error("ibtb_array: unknown write_index on write");

endmodule

`default_nettype wire

//--- src/ibtb_defs.svh
`ifndef IBTB_DEFS_SVH
`define IBTB_DEFS_SVH

// ------------------------------
// table geometry
// ------------------------------

// direct mapped table index width
`define IBTB_INDEX_BITS 6

// entry count follows from the index
`define IBTB_ENTRIES (1 << `IBTB_INDEX_BITS)

// partial tag kept per entry
`define IBTB_TAG_BITS 8

// ------------------------------
// core widths
// ------------------------------

// indirect global history length
`define IBTB_GH_BITS 8

// address space id of the running context
`define ASID_BITS 9

// word address width used by fetch
`define PC38_BITS 38

`endif

//--- src/ibtb_hash.sv
`timescale 1ns/1ps
`default_nettype none

`include "ibtb_defs.svh"

module ibtb_hash (
    // lookup key
    input  ibtb_pkg::PC38_t     src_pc38,
    input  ibtb_pkg::IBTB_GH_t  ibtb_gh,
    input  ibtb_pkg::ASID_t     asid,

    // folded result
    output ibtb_pkg::IBTB_index_t index,
    output ibtb_pkg::IBTB_tag_t   tag
);

    // ------------------------------
    // key fields
    // ------------------------------

    // low pc bits pick the set
    ibtb_pkg::IBTB_index_t pc_index_bits;
    // pc bits right above the index
    ibtb_pkg::IBTB_tag_t   pc_tag_bits;
    // only the low asid bits fit the tag
    ibtb_pkg::IBTB_tag_t   asid_tag_bits;
    // history swapped by nibble
    ibtb_pkg::IBTB_tag_t   gh_rot4;

    assign pc_index_bits = src_pc38[`IBTB_INDEX_BITS-1:0];
    assign pc_tag_bits   = src_pc38[`IBTB_INDEX_BITS +: `IBTB_TAG_BITS];
    assign asid_tag_bits = asid[`IBTB_TAG_BITS-1:0];

    // rotate by 4 so the top history bits land low in the tag
    // gh[7:6] never reach the index and only show up here
    assign gh_rot4 = {ibtb_gh[3:0], ibtb_gh[7:4]};

    // ------------------------------
    // fold
    // ------------------------------

    // index mixes pc with the low history bits
    assign index = pc_index_bits ^ ibtb_gh[`IBTB_INDEX_BITS-1:0];

    // tag separates contexts and the rest of the pc
    assign tag = pc_tag_bits ^ asid_tag_bits ^ gh_rot4;

endmodule

`default_nettype wire

//--- src/ibtb_pkg.sv
`default_nettype none

`include "ibtb_defs.svh"

package ibtb_pkg;

    // ------------------------------
    // front end address types
    // ------------------------------

    // one word per pc step
    typedef logic [`PC38_BITS-1:0] PC38_t;

    // recent indirect targets folded by the caller
    typedef logic [`IBTB_GH_BITS-1:0] IBTB_GH_t;

    // context id for reads and updates
    typedef logic [`ASID_BITS-1:0] ASID_t;

    // ------------------------------
    // table entry fields
    // ------------------------------

    // selects one of the direct mapped entries
    typedef logic [`IBTB_INDEX_BITS-1:0] IBTB_index_t;

    // compared against the stored tag on a read
    typedef logic [`IBTB_TAG_BITS-1:0] IBTB_tag_t;

endpackage

`default_nettype wire

//--- src/ibtb_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module ibtb_wrapper (
    // seq
    input  logic CLK,
    input  logic nRST,

    // arch state
    input  ibtb_pkg::ASID_t    next_arch_asid,

    // read
    input  ibtb_pkg::PC38_t    next_read_src_pc38,
    input  ibtb_pkg::IBTB_GH_t next_read_ibtb_gh,
    output ibtb_pkg::PC38_t    last_read_tgt_pc38,

    // update
    input  logic               next_update_valid,
    input  ibtb_pkg::PC38_t    next_update_src_pc38,
    input  ibtb_pkg::IBTB_GH_t next_update_ibtb_gh,
    input  ibtb_pkg::PC38_t    next_update_tgt_pc38
);

    // ------------------------------
    // core side signals
    // ------------------------------

    // arch state
    ibtb_pkg::ASID_t    arch_asid;

    // read
    ibtb_pkg::PC38_t    read_src_pc38;
    ibtb_pkg::IBTB_GH_t read_ibtb_gh;
    ibtb_pkg::PC38_t    read_tgt_pc38;

    // update
    logic               update_valid;
    ibtb_pkg::PC38_t    update_src_pc38;
    ibtb_pkg::IBTB_GH_t update_ibtb_gh;
    ibtb_pkg::PC38_t    update_tgt_pc38;

    // ------------------------------
    // core
    // ------------------------------

    ibtb u_ibtb (
        .CLK             (CLK),
        .nRST            (nRST),
        .arch_asid       (arch_asid),
        .read_src_pc38   (read_src_pc38),
        .read_ibtb_gh    (read_ibtb_gh),
        .read_tgt_pc38   (read_tgt_pc38),
        .update_valid    (update_valid),
        .update_src_pc38 (update_src_pc38),
        .update_ibtb_gh  (update_ibtb_gh),
        .update_tgt_pc38 (update_tgt_pc38)
    );

    // ------------------------------
    // stage registers
    // ------------------------------

    // inputs land at edge 1 and the prediction at edge 2
    // update strobe must reset low so nothing is trained
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            arch_asid          <= '0;
            read_src_pc38      <= '0;
            read_ibtb_gh       <= '0;
            last_read_tgt_pc38 <= '0;
            update_valid       <= 1'b0;
            update_src_pc38    <= '0;
            update_ibtb_gh     <= '0;
            update_tgt_pc38    <= '0;
        end
        else begin
            // input stage
            arch_asid          <= next_arch_asid;
            read_src_pc38      <= next_read_src_pc38;
            read_ibtb_gh       <= next_read_ibtb_gh;
            update_valid       <= next_update_valid;
            update_src_pc38    <= next_update_src_pc38;
            update_ibtb_gh     <= next_update_ibtb_gh;
            update_tgt_pc38    <= next_update_tgt_pc38;
            // output stage
            last_read_tgt_pc38 <= read_tgt_pc38;
        end
    end

endmodule

`default_nettype wire
